// File: Makefile
VERILATOR ?= verilator
TOP ?= dmacTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir
VFLAGS ?= --timing --assert -Wno-fatal
PASS ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -x '$(PASS)' > /dev/null

clean:
	rm -rf $(OBJDIR)

// File: bench/dmacTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacTb;

	localparam int limit = 3000;

	logic                          CLK;
	logic                          RST_N;
	logic [`DMAC_ADDR_W-1:0]       busAddr;
	logic [`DMAC_DATA_W-1:0]       busWriteData;
	logic [3:0]                    busByteEnable;
	logic                          busWrite;
	logic                          busRequest;
	logic [`DMAC_DATA_W-1:0]       busReadData;
	logic                          busSelect;
	logic                          nmi;
	logic [`DMAC_PERIPH_LINES-1:0] periphIrq;
	logic [`DMAC_ADDR_W-1:0]       memAddr;
	logic [`DMAC_DATA_W-1:0]       memWriteData;
	logic [3:0]                    memByteEnable;
	logic                          memWrite;
	logic                          memRequest;
	logic                          memWait;
	logic [`DMAC_DATA_W-1:0]       memReadData;
	logic [`DMAC_CHANNELS-1:0]     dmacIrq;

	logic [31:0]             lfsr = 32'h1a4ba30b;
	logic [7:0]              mem [int];
	logic [`DMAC_ADDR_W-1:0] writeLog [$];
	int                      writeCount = 0;
	logic                    waitNoise = 1'b0;
	int                      errorCount = 0;
	int                      testCount = 0;
	int                      testFails = 0;
	int                      testStartErrors = 0;

	dmacTop dmacTop_inst (.*);

	bind dmacTop dmacChecker checker_inst (
		.CLK(CLK), .RST_N(RST_N), .memRequest(memRequest), .memWrite(memWrite),
		.memWait(memWait), .memAddr(memAddr), .memWriteData(memWriteData),
		.memByteEnable(memByteEnable), .readPhase(readPhase), .writePhase(writePhase),
		.dmacIrq(dmacIrq)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [7:0] memByte(input logic [`DMAC_ADDR_W-1:0] a);
		if (mem.exists(int'(a))) return mem[int'(a)];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {4'h0, a[27:24]} ^ 8'h5A;
	endfunction

	function automatic logic [31:0] laneMerge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			r[8*i +: 8] = be[i] ? data[8*i +: 8] : old[8*i +: 8];
		end
		return r;
	endfunction

	function automatic logic [`DMAC_ADDR_W-1:0] regAddr(input int ch, input int ofs);
		return `DMAC_REG_BASE + `DMAC_ADDR_W'(ch * 16 + ofs);
	endfunction

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Memory model with big-endian lanes
	initial begin
		logic nextWait;
		logic [`DMAC_ADDR_W-1:0] base;
		forever begin
			@(negedge CLK);
			if (RST_N && memRequest && !memWait && memWrite) begin
				base = {memAddr[`DMAC_ADDR_W-1:2], 2'b00};
				for (int i = 0; i < 4; i++) begin
					if (memByteEnable[i]) mem[int'(base) + 3 - i] = memWriteData[8*i +: 8];
				end
				writeCount++;
				writeLog.push_back(memAddr);
			end
			nextWait = waitNoise ? (randBits(2) == 0) : 1'b0;
			@(posedge CLK);
			#5;
			memWait = nextWait;
			base = {memAddr[`DMAC_ADDR_W-1:2], 2'b00};
			memReadData = {memByte(base), memByte(base + 1), memByte(base + 2), memByte(base + 3)};
		end
	end

	task automatic tick();
		@(posedge CLK);
		#5;
	endtask

	task automatic reportValue(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
		errorCount++;
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, limit);
		errorCount++;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testStartErrors) begin
			$display("%s: passed", name);
		end else begin
			testFails++;
			$display("%s: failed with %0d errors", name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	task automatic writeReg(input logic [`DMAC_ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		busAddr = addr;
		busWriteData = data;
		busByteEnable = be;
		busWrite = 1'b1;
		busRequest = 1'b1;
		tick();
		busRequest = 1'b0;
		busWrite = 1'b0;
	endtask

	task automatic readReg(input logic [`DMAC_ADDR_W-1:0] addr, output logic [31:0] data);
		busAddr = addr;
		busWrite = 1'b0;
		busRequest = 1'b1;
		tick();
		busRequest = 1'b0;
		data = busReadData;
	endtask

	task automatic setupChannel(input int ch, input logic [`DMAC_ADDR_W-1:0] src,
			input logic [`DMAC_ADDR_W-1:0] dst, input logic [15:0] count,
			input logic [15:0] chcr);
		writeReg(regAddr(ch, 0), {4'h0, src}, 4'b1111);
		writeReg(regAddr(ch, 4), {4'h0, dst}, 4'b1111);
		writeReg(regAddr(ch, 8), {16'h0, count}, 4'b0011);
		writeReg(regAddr(ch, 12), {16'h0, chcr}, 4'b0011);
	endtask

	// DMAOR write also clears NMIF
	task automatic enableDma(input logic on);
		writeReg(regAddr(0, 8), {15'h0, on, 16'h0}, 4'b1100);
	endtask

	task automatic waitIrq(input int ch);
		int n;
		for (n = 0; n < limit && !dmacIrq[ch]; n++) tick();
		if (n == limit) reportTimeout($sformatf("transfer end interrupt of channel %0d", ch));
	endtask

	task automatic waitWrites(input int target);
		int n;
		for (n = 0; n < limit && writeCount < target; n++) tick();
		if (n == limit) reportTimeout("memory write");
	endtask

	task automatic waitQuiet();
		int n;
		int quiet;
		quiet = 0;
		for (n = 0; n < limit && quiet < 4; n++) begin
			quiet = memRequest ? 0 : quiet + 1;
			tick();
		end
		if (n == limit) reportTimeout("end of memory activity");
	endtask

	task automatic registerTest();
		logic [27:0] eSar [4];
		logic [27:0] eDar [4];
		logic [15:0] eTcr [4];
		logic [15:0] eChcr [4];
		logic [15:0] eDmaor;
		logic [31:0] data;
		logic [31:0] merged;
		logic [3:0]  be;
		logic [15:0] nextDmaor;
		logic [15:0] nextChcr;
		int          ch;
		int          ofs;
		for (int i = 0; i < 4; i++) begin
			eSar[i] = '0;
			eDar[i] = '0;
			eTcr[i] = '0;
			eChcr[i] = '0;
		end
		nmi = 1'b0;
		tick();
		nmi = 1'b1;
		eDmaor = 16'h0004;
		for (int k = 0; k < 60; k++) begin
			ch = int'(randBits(2));
			ofs = int'(randBits(2));
			data = randBits(32);
			be = randBits(4);
			// Keep DME low so no transfer starts
			if (ofs == 2) data[16] = 1'b0;
			writeReg(regAddr(ch, ofs * 4), data, be);
			case (ofs)
				0: eSar[ch] = laneMerge({4'h0, eSar[ch]}, data, be) & 32'h0FFFFFFF;
				1: eDar[ch] = laneMerge({4'h0, eDar[ch]}, data, be) & 32'h0FFFFFFF;
				2: begin
					merged = laneMerge({eDmaor, eTcr[ch]}, data, be);
					if (be[1:0] != 0) eTcr[ch] = merged[15:0];
					nextDmaor = merged[31:16] & 16'h0005;
					nextDmaor[2] = eDmaor[2] & merged[18];
					if (be[3:2] != 0) eDmaor = nextDmaor;
				end
				default: begin
					merged = laneMerge({16'h0, eChcr[ch]}, data, be);
					nextChcr = merged[15:0] & 16'hFF0F;
					nextChcr[1] = eChcr[ch][1] & merged[1];
					if (be[1:0] != 0) eChcr[ch] = nextChcr;
				end
			endcase
		end
		for (int i = 0; i < 4; i++) begin
			readReg(regAddr(i, 0), data);
			if (data !== {4'h0, eSar[i]}) reportValue("SAR", data, {4'h0, eSar[i]});
			readReg(regAddr(i, 4), data);
			if (data !== {4'h0, eDar[i]}) reportValue("DAR", data, {4'h0, eDar[i]});
			readReg(regAddr(i, 8), data);
			if (data !== {eDmaor, eTcr[i]}) reportValue("DMAOR/TCR", data, {eDmaor, eTcr[i]});
			readReg(regAddr(i, 12), data);
			if (data !== {16'h0, eChcr[i]}) reportValue("CHCR", data, {16'h0, eChcr[i]});
		end
		// Window edges and the addresses just outside them
		readReg(`DMAC_REG_BASE, data);
		if (busSelect !== 1'b1) reportValue("busSelect at window start", busSelect, 1);
		readReg(`DMAC_REG_LAST, data);
		if (busSelect !== 1'b1) reportValue("busSelect at window end", busSelect, 1);
		readReg(`DMAC_REG_BASE - 28'h1, data);
		if (busSelect !== 1'b0) reportValue("busSelect below window", busSelect, 0);
		if (data !== 32'h0) reportValue("below window", data, 32'h0);
		readReg(`DMAC_REG_LAST + 28'h1, data);
		if (busSelect !== 1'b0) reportValue("busSelect above window", busSelect, 0);
		if (data !== 32'h0) reportValue("above window", data, 32'h0);
		for (int i = 0; i < 4; i++) begin
			writeReg(regAddr(i, 0), 32'h0, 4'b1111);
			writeReg(regAddr(i, 4), 32'h0, 4'b1111);
			writeReg(regAddr(i, 8), 32'h0, 4'b1111);
			writeReg(regAddr(i, 12), 32'h0, 4'b1111);
		end
		finishTest("Register access");
	endtask

	task automatic byteCopyTest();
		logic [27:0] src;
		logic [27:0] dst;
		logic [31:0] data;
		int          n;
		n = 3 + int'(randBits(3));
		src = 28'h0010000 + randBits(4);
		dst = 28'h0020000 + randBits(4);
		for (int i = 0; i < n; i++) mem[int'(src) + i] = randBits(8);
		setupChannel(1, src, dst, 16'(n), 16'h5C05);
		enableDma(1'b1);
		waitIrq(1);
		readReg(regAddr(1, 8), data);
		if (data[15:0] !== 16'h0) reportValue("TCR", data[15:0], 0);
		readReg(regAddr(1, 12), data);
		if (data[1] !== 1'b1) reportValue("CHCR TE", data, data | 32'h2);
		readReg(regAddr(1, 0), data);
		if (data !== {4'h0, src + 28'(n)}) reportValue("SAR", data, {4'h0, src + 28'(n)});
		readReg(regAddr(1, 4), data);
		if (data !== {4'h0, dst + 28'(n)}) reportValue("DAR", data, {4'h0, dst + 28'(n)});
		for (int i = 0; i < n; i++) begin
			if (memByte(dst + 28'(i)) !== memByte(src + 28'(i))) begin
				reportValue("destination byte", memByte(dst + 28'(i)), memByte(src + 28'(i)));
			end
		end
		enableDma(1'b0);
		// TE ignores a written 1 and clears on a written 0
		writeReg(regAddr(1, 12), 32'h5C06, 4'b0011);
		readReg(regAddr(1, 12), data);
		if (data !== 32'h5C06) reportValue("CHCR after TE write of 1", data, 32'h5C06);
		writeReg(regAddr(1, 12), 32'h0, 4'b0011);
		readReg(regAddr(1, 12), data);
		if (data !== 32'h0) reportValue("CHCR after TE write of 0", data, 32'h0);
		if (dmacIrq[1] !== 1'b0) reportValue("dmacIrq after TE clear", dmacIrq, 0);
		finishTest("Auto-request byte copy");
	endtask

	task automatic wordModeTest();
		logic [27:0] src;
		logic [27:0] dst;
		logic [27:0] last;
		logic [31:0] data;
		int          n;
		int          k;
		n = 2 + int'(randBits(2));
		src = 28'h0030100 + (randBits(3) << 1);
		dst = 28'h0040000 + (randBits(3) << 1);
		setupChannel(2, src, dst, 16'(n), 16'h2C09);
		enableDma(1'b1);
		data = '0;
		for (k = 0; k < limit && !data[1]; k++) readReg(regAddr(2, 12), data);
		if (k == limit) reportTimeout("word transfer end flag");
		last = src - 28'(2 * (n - 1));
		readReg(regAddr(2, 0), data);
		if (data !== {4'h0, src - 28'(2 * n)}) reportValue("SAR", data, {4'h0, src - 28'(2 * n)});
		readReg(regAddr(2, 4), data);
		if (data !== {4'h0, dst}) reportValue("DAR", data, {4'h0, dst});
		if (memByte(dst) !== memByte(last)) reportValue("high byte", memByte(dst), memByte(last));
		if (memByte(dst + 1) !== memByte(last + 1)) begin
			reportValue("low byte", memByte(dst + 1), memByte(last + 1));
		end
		enableDma(1'b0);
		writeReg(regAddr(2, 12), 32'h0, 4'b0011);
		finishTest("Word transfers with address modes");
	endtask

	task automatic periphTest();
		logic [2:0] k;
		logic [3:0] rs;
		int         start;
		k = randBits(3);
		rs = `DMAC_RS_PERIPH_FIRST + 4'(k);
		setupChannel(3, 28'h0050000, 28'h0060000, 16'd16, {2'b01, 2'b01, rs, 8'h01});
		enableDma(1'b1);
		start = writeCount;
		for (int p = 0; p < 4; p++) begin
			repeat (2) tick();
			periphIrq[k] = 1'b1;
			tick();
			periphIrq[k] = 1'b0;
			waitWrites(start + p + 1);
			repeat (12) tick();
		end
		if (writeCount - start != 4) reportValue("write count", writeCount - start, 4);
		enableDma(1'b0);
		writeReg(regAddr(3, 12), 32'h0, 4'b0011);
		finishTest("Peripheral source");
	endtask

	task automatic priorityTest();
		int   ch0;
		int   ch2;
		logic lateCh0;
		setupChannel(0, 28'h0070000, 28'h0071000, 16'd3, 16'h5C05);
		setupChannel(2, 28'h0072000, 28'h0073000, 16'd3, 16'h5C05);
		writeLog.delete();
		enableDma(1'b1);
		waitIrq(0);
		waitIrq(2);
		ch0 = 0;
		ch2 = 0;
		lateCh0 = 1'b0;
		foreach (writeLog[i]) begin
			if (writeLog[i] >= 28'h0073000) ch2++;
			else begin
				ch0++;
				if (ch2 != 0) lateCh0 = 1'b1;
			end
		end
		if (lateCh0) begin
			$display("FAIL %0t: channel 0 write after a channel 2 write", $time);
			errorCount++;
		end
		if (ch0 != 3) reportValue("channel 0 writes", ch0, 3);
		if (ch2 != 3) reportValue("channel 2 writes", ch2, 3);
		enableDma(1'b0);
		writeReg(regAddr(0, 12), 32'h0, 4'b0011);
		writeReg(regAddr(2, 12), 32'h0, 4'b0011);
		finishTest("Priority");
	endtask

	task automatic nmiTest();
		logic [31:0] data;
		int          frozen;
		int          start;
		start = writeCount;
		setupChannel(1, 28'h0080000, 28'h0081000, 16'd40, 16'h5C01);
		enableDma(1'b1);
		waitWrites(start + 2);
		nmi = 1'b0;
		tick();
		nmi = 1'b1;
		waitQuiet();
		frozen = writeCount;
		repeat (20) tick();
		if (writeCount != frozen) reportValue("writes after NMI", writeCount, frozen);
		if (writeCount - start >= 40) reportValue("transfers before halt", writeCount - start, 39);
		readReg(regAddr(0, 8), data);
		if (data[18] !== 1'b1) reportValue("DMAOR NMIF", data, data | 32'h40000);
		enableDma(1'b0);
		writeReg(regAddr(1, 12), 32'h0, 4'b0011);
		finishTest("NMI");
	endtask

	initial begin
		RST_N = 1'b0;
		busAddr = '0;
		busWriteData = '0;
		busByteEnable = '0;
		busWrite = 1'b0;
		busRequest = 1'b0;
		nmi = 1'b1;
		periphIrq = '0;
		memWait = 1'b0;
		memReadData = '0;
		repeat (2) @(posedge CLK);
		#5;
		RST_N = 1'b1;
		tick();
		registerTest();
		waitNoise = 1'b1;
		byteCopyTest();
		wordModeTest();
		periphTest();
		priorityTest();
		nmiTest();
		$display("Tests: %0d run, %0d failed, %0d errors", testCount, testFails, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/dmac_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacChecker (
	input wire                        CLK,
	input wire                        RST_N,
	input wire                        memRequest,
	input wire                        memWrite,
	input wire                        memWait,
	input wire [`DMAC_ADDR_W-1:0]     memAddr,
	input wire [`DMAC_DATA_W-1:0]     memWriteData,
	input wire [3:0]                  memByteEnable,
	input wire                        readPhase,
	input wire                        writePhase,
	input wire [`DMAC_CHANNELS-1:0]   dmacIrq
);

	writeNeedsRequest: assert property (@(posedge CLK) disable iff (!RST_N)
		memWrite |-> memRequest)
		else $error("memWrite high without memRequest");

	// Held access stays frozen under wait
	heldWhileWait: assert property (@(posedge CLK) disable iff (!RST_N)
		memRequest && memWait |=> $stable(memAddr) && $stable(memWriteData)
			&& $stable(memByteEnable) && $stable(memWrite) && memRequest)
		else $error("memory outputs changed while memWait was high");

	onePhase: assert property (@(posedge CLK) disable iff (!RST_N)
		!(readPhase && writePhase))
		else $error("read and write phase active together");

	irqQuietAfterReset: assert property (@(posedge CLK)
		$rose(RST_N) |-> dmacIrq == '0)
		else $error("dmacIrq set right after reset");

endmodule

`default_nettype wire

// File: source/dmacBusResult.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacBusResult import dmacPkg::*; (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      readPhase,
	input  wire                      writePhase,
	input  wire                      sourceDone,
	input  chcrType                  activeChcr,
	input  wire  [`DMAC_ADDR_W-1:0]  activeSar,
	input  wire  [`DMAC_ADDR_W-1:0]  activeDar,
	input  wire  [`DMAC_DATA_W-1:0]  memReadData,
	output logic [`DMAC_ADDR_W-1:0]  memAddr,
	output logic [`DMAC_DATA_W-1:0]  memWriteData,
	output logic [3:0]               memByteEnable,
	output logic                     memWrite,
	output logic                     memRequest
);

	logic [15:0] captured;
	logic [7:0]  readByte;
	logic [15:0] readHalf;

	// Lane 3 holds byte 0
	function automatic logic [3:0] laneEnable(input logic [1:0] addr, input logic wordSize);
		logic [3:0] enable;
		if (wordSize) begin
			enable = addr[1] ? 4'b0011 : 4'b1100;
		end else begin
			enable = 4'b1000 >> addr;
		end
		return enable;
	endfunction

	assign readByte = memReadData[8 * (3 - activeSar[1:0]) +: 8];
	assign readHalf = activeSar[1] ? memReadData[15:0] : memReadData[31:16];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			captured <= '0;
		end else if (sourceDone) begin
			captured <= activeChcr.TS ? readHalf : {8'h00, readByte};
		end
	end

	assign memRequest = readPhase | writePhase;
	assign memWrite = writePhase;
	assign memAddr = readPhase ? activeSar : activeDar;
	assign memByteEnable = laneEnable(memAddr[1:0], activeChcr.TS) & {4{memRequest}};
	assign memWriteData = activeChcr.TS ? {2{captured}} : {4{captured[7:0]}};

endmodule

`default_nettype wire

// File: source/dmacPkg.sv
`default_nettype none
`include "dmac_settings.svh"

package dmacPkg;

	// Channel control word
	typedef struct packed {
		logic [1:0] DM;
		logic [1:0] SM;
		logic [3:0] RS;
		logic [3:0] reserved;
		logic       TS;
		logic       IE;
		logic       TE;
		logic       DE;
	} chcrType;

	// Shared operation word
	typedef struct packed {
		logic [12:0] reserved;
		logic        NMIF;
		logic        reservedLow;
		logic        DME;
	} dmaorType;

	typedef logic [$clog2(`DMAC_CHANNELS)-1:0] channelType;

	typedef enum logic [1:0] {
		addrFixed     = 2'd0,
		addrIncrement = 2'd1,
		addrDecrement = 2'd2
	} addrModeType;

endpackage

`default_nettype wire

// File: source/dmacRegisters.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacRegisters import dmacPkg::*; (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire  [`DMAC_ADDR_W-1:0]            busAddr,
	input  wire  [`DMAC_DATA_W-1:0]            busWriteData,
	input  wire  [3:0]                         busByteEnable,
	input  wire                                busWrite,
	input  wire                                busRequest,
	input  wire                                nmi,
	input  channelType                         activeChannel,
	input  wire                                sourceDone,
	input  wire                                destDone,
	output logic [`DMAC_DATA_W-1:0]            busReadData,
	output logic                               busSelect,
	output logic [`DMAC_CHANNELS-1:0]          channelReady,
	output logic [`DMAC_CHANNELS-1:0][3:0]     chcrRs,
	output chcrType                            activeChcr,
	output logic [`DMAC_ADDR_W-1:0]            activeSar,
	output logic [`DMAC_ADDR_W-1:0]            activeDar,
	output logic [`DMAC_CHANNELS-1:0]          dmacIrq
);

	localparam int padW = `DMAC_DATA_W - `DMAC_ADDR_W;

	logic [`DMAC_ADDR_W-1:0]  sar [`DMAC_CHANNELS];
	logic [`DMAC_ADDR_W-1:0]  dar [`DMAC_CHANNELS];
	logic [`DMAC_COUNT_W-1:0] tcr [`DMAC_CHANNELS];
	chcrType                  chcr [`DMAC_CHANNELS];
	dmaorType                 dmaor;
	channelType               busChannel;

	// Big-endian lanes, enable bit 3 covers bits 31:24
	function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] enable);
		logic [31:0] res;
		for (int i = 0; i < 4; i++) begin
			res[8*i +: 8] = enable[i] ? data[8*i +: 8] : old[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic [`DMAC_ADDR_W-1:0] stepAddr(input logic [`DMAC_ADDR_W-1:0] addr,
			input logic [1:0] mode, input logic wordSize);
		logic [`DMAC_ADDR_W-1:0] size;
		size = {{(`DMAC_ADDR_W-2){1'b0}}, wordSize, ~wordSize};
		case (addrModeType'(mode))
			addrIncrement: return addr + size;
			addrDecrement: return addr - size;
			default: return addr;
		endcase
	endfunction

	assign busSelect = (busAddr >= `DMAC_REG_BASE) && (busAddr <= `DMAC_REG_LAST);
	assign busChannel = channelType'(busAddr[5:4]);

	always_ff @(posedge CLK or negedge RST_N) begin
		logic [31:0]              merged;
		logic [`DMAC_COUNT_W-1:0] tcrNext;
		chcrType                  chcrNew;
		dmaorType                 dmaorNew;
		if (!RST_N) begin
			for (int i = 0; i < `DMAC_CHANNELS; i++) begin
				sar[i] <= '0;
				dar[i] <= '0;
				tcr[i] <= '0;
				chcr[i] <= '0;
			end
			dmaor <= '0;
		end else begin
			tcrNext = tcr[activeChannel] - 1'b1;
			if (sourceDone) begin
				sar[activeChannel] <= stepAddr(sar[activeChannel], chcr[activeChannel].SM,
					chcr[activeChannel].TS);
			end
			if (destDone) begin
				dar[activeChannel] <= stepAddr(dar[activeChannel], chcr[activeChannel].DM,
					chcr[activeChannel].TS);
				tcr[activeChannel] <= tcrNext;
				if (tcrNext == '0) begin
					chcr[activeChannel].TE <= 1'b1;
				end
			end

			if (busSelect && busRequest && busWrite) begin
				case ({busAddr[3:2], 2'b00})
					`DMAC_OFS_SAR: begin
						merged = mergeLanes({{padW{1'b0}}, sar[busChannel]}, busWriteData,
							busByteEnable);
						if (|busByteEnable) sar[busChannel] <= merged[`DMAC_ADDR_W-1:0];
					end
					`DMAC_OFS_DAR: begin
						merged = mergeLanes({{padW{1'b0}}, dar[busChannel]}, busWriteData,
							busByteEnable);
						if (|busByteEnable) dar[busChannel] <= merged[`DMAC_ADDR_W-1:0];
					end
					`DMAC_OFS_TCR: begin
						merged = mergeLanes({dmaor, tcr[busChannel]}, busWriteData, busByteEnable);
						if (|busByteEnable[1:0]) tcr[busChannel] <= merged[15:0];
						// NMIF only clears, never sets from the bus
						dmaorNew = merged[31:16] & `DMAC_DMAOR_WMASK;
						dmaorNew.NMIF = dmaor.NMIF & merged[18];
						if (|busByteEnable[3:2]) dmaor <= dmaorNew;
					end
					default: begin
						merged = mergeLanes({16'h0000, chcr[busChannel]}, busWriteData,
							busByteEnable);
						chcrNew = merged[15:0] & `DMAC_CHCR_WMASK;
						chcrNew.TE = chcr[busChannel].TE & merged[1];
						if (|busByteEnable[1:0]) chcr[busChannel] <= chcrNew;
					end
				endcase
			end

			if (!nmi) begin
				dmaor.NMIF <= 1'b1;
			end
		end
	end

	// Registered readback
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busReadData <= '0;
		end else if (busRequest && !busWrite) begin
			if (!busSelect) begin
				busReadData <= '0;
			end else begin
				case ({busAddr[3:2], 2'b00})
					`DMAC_OFS_SAR: busReadData <= {{padW{1'b0}}, sar[busChannel]};
					`DMAC_OFS_DAR: busReadData <= {{padW{1'b0}}, dar[busChannel]};
					`DMAC_OFS_TCR: busReadData <= {dmaor, tcr[busChannel]};
					default: busReadData <= {16'h0000, chcr[busChannel]};
				endcase
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `DMAC_CHANNELS; i++) begin
			channelReady[i] = dmaor.DME & chcr[i].DE & ~chcr[i].TE & ~dmaor.NMIF;
			chcrRs[i] = chcr[i].RS;
			dmacIrq[i] = chcr[i].TE & chcr[i].IE;
		end
	end

	assign activeChcr = chcr[activeChannel];
	assign activeSar = sar[activeChannel];
	assign activeDar = dar[activeChannel];

endmodule

`default_nettype wire

// File: source/dmacRequestDecode.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacRequestDecode import dmacPkg::*; (
	input  wire                                CLK,
	input  wire                                RST_N,
	input  wire  [`DMAC_PERIPH_LINES-1:0]      periphIrq,
	input  wire  [`DMAC_CHANNELS-1:0][3:0]     chcrRs,
	input  wire  [`DMAC_CHANNELS-1:0]          channelReady,
	input  wire                                busy,
	output logic                               startPulse,
	output channelType                         startChannel
);

	logic [`DMAC_CHANNELS-1:0] requestLevel;
	logic [`DMAC_CHANNELS-1:0] pending;
	logic [`DMAC_CHANNELS-1:0] eligible;
	channelType                nextChannel;

	function automatic logic sourceLevel(input logic [3:0] rs,
			input logic [`DMAC_PERIPH_LINES-1:0] irq);
		logic level;
		if (rs >= `DMAC_RS_PERIPH_FIRST && rs <= `DMAC_RS_PERIPH_LAST) begin
			level = irq[rs - `DMAC_RS_PERIPH_FIRST];
		end else if (rs == `DMAC_RS_AUTO) begin
			level = 1'b1;
		end else if (rs == `DMAC_RS_ADC) begin
			level = irq[`DMAC_PERIPH_LINES-1];
		end else begin
			level = 1'b0;
		end
		return level;
	endfunction

	always_comb begin
		for (int i = 0; i < `DMAC_CHANNELS; i++) begin
			requestLevel[i] = sourceLevel(chcrRs[i], periphIrq);
		end
	end

	// Drop latches of channels that went unready since they were set
	assign eligible = pending & channelReady;

	// Channel 0 wins
	always_comb begin
		nextChannel = '0;
		for (int i = `DMAC_CHANNELS - 1; i >= 0; i--) begin
			if (eligible[i]) nextChannel = channelType'(i);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < `DMAC_CHANNELS; i++) begin
				if (!channelReady[i]) begin
					pending[i] <= 1'b0;
				end else if (startPulse && startChannel == channelType'(i)) begin
					pending[i] <= 1'b0;
				end else if (requestLevel[i]) begin
					pending[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			startPulse <= 1'b0;
			startChannel <= '0;
		end else if (!busy && !startPulse && |eligible) begin
			startPulse <= 1'b1;
			startChannel <= nextChannel;
		end else begin
			startPulse <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/dmacTop.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacTop import dmacPkg::*; (
	input  wire                            CLK,
	input  wire                            RST_N,
	input  wire  [`DMAC_ADDR_W-1:0]        busAddr,
	input  wire  [`DMAC_DATA_W-1:0]        busWriteData,
	input  wire  [3:0]                     busByteEnable,
	input  wire                            busWrite,
	input  wire                            busRequest,
	output logic [`DMAC_DATA_W-1:0]        busReadData,
	output logic                           busSelect,
	input  wire                            nmi,
	input  wire  [`DMAC_PERIPH_LINES-1:0]  periphIrq,
	output logic [`DMAC_ADDR_W-1:0]        memAddr,
	output logic [`DMAC_DATA_W-1:0]        memWriteData,
	output logic [3:0]                     memByteEnable,
	output logic                           memWrite,
	output logic                           memRequest,
	input  wire                            memWait,
	input  wire  [`DMAC_DATA_W-1:0]        memReadData,
	output logic [`DMAC_CHANNELS-1:0]      dmacIrq
);

	logic [`DMAC_CHANNELS-1:0]      channelReady;
	logic [`DMAC_CHANNELS-1:0][3:0] chcrRs;
	chcrType                        activeChcr;
	logic [`DMAC_ADDR_W-1:0]        activeSar;
	logic [`DMAC_ADDR_W-1:0]        activeDar;
	logic                           startPulse;
	channelType                     startChannel;
	logic                           busy;
	channelType                     activeChannel;
	logic                           readPhase;
	logic                           writePhase;
	logic                           sourceDone;
	logic                           destDone;

	dmacRegisters registers_inst (
		.CLK           (CLK),
		.RST_N         (RST_N),
		.busAddr       (busAddr),
		.busWriteData  (busWriteData),
		.busByteEnable (busByteEnable),
		.busWrite      (busWrite),
		.busRequest    (busRequest),
		.nmi           (nmi),
		.activeChannel (activeChannel),
		.sourceDone    (sourceDone),
		.destDone      (destDone),
		.busReadData   (busReadData),
		.busSelect     (busSelect),
		.channelReady  (channelReady),
		.chcrRs        (chcrRs),
		.activeChcr    (activeChcr),
		.activeSar     (activeSar),
		.activeDar     (activeDar),
		.dmacIrq       (dmacIrq)
	);

	dmacRequestDecode requestDecode_inst (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.periphIrq    (periphIrq),
		.chcrRs       (chcrRs),
		.channelReady (channelReady),
		.busy         (busy),
		.startPulse   (startPulse),
		.startChannel (startChannel)
	);

	dmacTransferExecute transferExecute_inst (
		.CLK           (CLK),
		.RST_N         (RST_N),
		.startPulse    (startPulse),
		.startChannel  (startChannel),
		.memWait       (memWait),
		.busy          (busy),
		.activeChannel (activeChannel),
		.readPhase     (readPhase),
		.writePhase    (writePhase),
		.sourceDone    (sourceDone),
		.destDone      (destDone)
	);

	dmacBusResult busResult_inst (
		.CLK           (CLK),
		.RST_N         (RST_N),
		.readPhase     (readPhase),
		.writePhase    (writePhase),
		.sourceDone    (sourceDone),
		.activeChcr    (activeChcr),
		.activeSar     (activeSar),
		.activeDar     (activeDar),
		.memReadData   (memReadData),
		.memAddr       (memAddr),
		.memWriteData  (memWriteData),
		.memByteEnable (memByteEnable),
		.memWrite      (memWrite),
		.memRequest    (memRequest)
	);

endmodule

`default_nettype wire

// File: source/dmacTransferExecute.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmac_settings.svh"

module dmacTransferExecute import dmacPkg::*; (
	input  wire        CLK,
	input  wire        RST_N,
	input  wire        startPulse,
	input  channelType startChannel,
	input  wire        memWait,
	output logic       busy,
	output channelType activeChannel,
	output logic       readPhase,
	output logic       writePhase,
	output logic       sourceDone,
	output logic       destDone
);

	typedef enum logic [1:0] {
		stIdle,
		stRead,
		stWrite
	} stateType;

	stateType state;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= stIdle;
			activeChannel <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (startPulse) begin
						state <= stRead;
						activeChannel <= startChannel;
					end
				end
				// Each phase holds until the memory drops its wait
				stRead: begin
					if (!memWait) state <= stWrite;
				end
				stWrite: begin
					if (!memWait) state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	assign busy = (state != stIdle);
	assign readPhase = (state == stRead);
	assign writePhase = (state == stWrite);

	// Completion edge of each access
	assign sourceDone = readPhase & ~memWait;
	assign destDone = writePhase & ~memWait;

endmodule

`default_nettype wire

// File: source/dmac_settings.svh
`ifndef DMAC_SETTINGS_SVH
`define DMAC_SETTINGS_SVH

// Datapath widths
`define DMAC_CHANNELS 4
`define DMAC_ADDR_W 28
`define DMAC_DATA_W 32
`define DMAC_COUNT_W 16

// Register window on the CPU bus
`define DMAC_REG_BASE 28'h5FFFF40
`define DMAC_REG_LAST 28'h5FFFF7F

// Byte offsets inside one channel's 16-byte block
`define DMAC_OFS_SAR 4'h0
`define DMAC_OFS_DAR 4'h4
`define DMAC_OFS_TCR 4'h8
`define DMAC_OFS_CHCR 4'hC

`define DMAC_CHCR_WMASK 16'hFF0F
`define DMAC_DMAOR_WMASK 16'h0005

// Request source codes
`define DMAC_RS_AUTO 4'd12
`define DMAC_RS_PERIPH_FIRST 4'd4
`define DMAC_RS_PERIPH_LAST 4'd11
`define DMAC_RS_ADC 4'd13
`define DMAC_PERIPH_LINES 9

`endif

// File: sources.f
+incdir+source
source/dmacPkg.sv
source/dmacRegisters.sv
source/dmacRequestDecode.sv
source/dmacTransferExecute.sv
source/dmacBusResult.sv
source/dmacTop.sv
bench/dmac_checker.sv
bench/dmacTb.sv
